/* project.f */
+incdir+verilog
verilog/dcache_pkg.sv
verilog/dc_line_array.sv
verilog/dc_mshr.sv
verilog/dc_request_ctrl.sv
verilog/dcache_top.sv
tb/dc_mem_model.sv
tb/dcache_tb.sv

/* Bender.yml */
package:
  name: dcache

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/dcache_pkg.sv
      - verilog/dc_line_array.sv
      - verilog/dc_mshr.sv
      - verilog/dc_request_ctrl.sv
      - verilog/dcache_top.sv
  - target: simulation
    include_dirs:
      - verilog
    files:
      - tb/dc_mem_model.sv
      - tb/dcache_tb.sv

/* tb/dcache_tb.sv */
`timescale 1ns/10ps
`include "dcache_defs.svh"

module dcache_tb;

    logic                     clock;
    logic                     reset;
    dcache_pkg::dc_request_t  dcache_request;
    logic                     stall;
    dcache_pkg::dc_response_t dcache_response;
    dcache_pkg::mem_cmd_e     mem_command;
    dcache_pkg::addr_t        mem_addr;
    dcache_pkg::block_t       mem_data;
    dcache_pkg::mem_tag_t     mem_response;
    dcache_pkg::mem_tag_t     mem_fill_tag;
    dcache_pkg::block_t       mem_fill_data;

    logic [7:0]            sb_bytes [dcache_pkg::addr_t];   // scoreboard, one entry per byte
    logic                  res_valid [`DC_N_LINES];         // line each index should hold
    dcache_pkg::line_tag_t res_tag [`DC_N_LINES];
    dcache_pkg::word_t     exp_data;
    dcache_pkg::word_t     resp_expect;                     // expectation for the response
    logic                  expect_hit;
    logic                  hit_issue;
    logic                  started;
    int                    errors;
    int                    timeouts;

    dcache_top uut (
        .clock           (clock),
        .reset           (reset),
        .dcache_request  (dcache_request),
        .stall           (stall),
        .dcache_response (dcache_response),
        .mem_command     (mem_command),
        .mem_addr        (mem_addr),
        .mem_data        (mem_data),
        .mem_response    (mem_response),
        .mem_fill_tag    (mem_fill_tag),
        .mem_fill_data   (mem_fill_data)
    );

    dc_mem_model u_mem (
        .clock         (clock),
        .reset         (reset),
        .mem_command   (mem_command),
        .mem_addr      (mem_addr),
        .mem_data      (mem_data),
        .mem_response  (mem_response),
        .mem_fill_tag  (mem_fill_tag),
        .mem_fill_data (mem_fill_data)
    );

    always #4 clock = ~clock;

    // memory starts with each line holding its own address twice
    function automatic logic [7:0] initial_byte(input dcache_pkg::addr_t a);
        dcache_pkg::addr_t line;
        line = a & ~(`DC_BLOCK_BYTES - 1);
        return line[8*(a % 4) +: 8];
    endfunction

    function automatic dcache_pkg::word_t expected_load(input dcache_pkg::addr_t a, input int n);
        dcache_pkg::word_t v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v[8*i +: 8] = sb_bytes.exists(a + i) ? sb_bytes[a + i] : initial_byte(a + i);
        end
        return v;
    endfunction

    // called 1 ns after an edge, returns 1 ns after the edge that ends the access
    task automatic access(input dcache_pkg::mem_op_e op, input dcache_pkg::mem_size_e size,
                          input dcache_pkg::addr_t addr, input dcache_pkg::word_t wdata);
        int                    nbytes;
        int                    cycles;
        dcache_pkg::line_idx_t idx;
        dcache_pkg::line_tag_t tag;
        nbytes     = 1 << size;
        idx        = addr[`DC_BO_BITS +: `DC_IDX_BITS];
        tag        = addr[`DC_XLEN-1 -: `DC_TAG_BITS];
        expect_hit = res_valid[idx] && (res_tag[idx] == tag);
        res_valid[idx] = 1'b1;   // hit or miss, the line ends up resident
        res_tag[idx]   = tag;
        exp_data = '0;           // stores answer with zero
        if (op == dcache_pkg::op_read) begin
            exp_data = expected_load(addr, nbytes);
        end else begin
            for (int i = 0; i < nbytes; i++) begin
                sb_bytes[addr + i] = wdata[8*i +: 8];
            end
        end
        dcache_request = '{valid: 1'b1, op: op, size: size, addr: addr, wdata: wdata};
        started        = 1'b1;
        @(posedge clock);
        #1;
        cycles = 0;
        while (stall && cycles < 400) begin
            @(posedge clock);
            #1;
            cycles++;
        end
        if (stall) begin
            timeouts++;
            $display("timeout: stall stayed high for the request to address %h", addr);
        end
    endtask

    assign hit_issue = dcache_request.valid && !stall && expect_hit;

    always @(posedge clock) begin
        resp_expect <= exp_data;
    end

    a_idle_after_reset: assert property (@(posedge clock) disable iff (reset)
        !started |-> (!stall && mem_command == dcache_pkg::cmd_none && !dcache_response.valid))
        else begin
            errors++;
            $display("ERR %0t: activity seen before the first request", $time);
        end

    a_response_data: assert property (@(posedge clock) disable iff (reset)
        dcache_response.valid |-> (dcache_response.data == resp_expect))
        else begin
            errors++;
            $display("ERR %0t: response data %h, expected %h", $time,
                     dcache_response.data, resp_expect);
        end

    a_hit_latency: assert property (@(posedge clock) disable iff (reset)
        hit_issue |=> (dcache_response.valid && !stall))
        else begin
            errors++;
            $display("ERR %0t: hit did not answer one cycle later with stall low", $time);
        end

    a_miss_stalls: assert property (@(posedge clock) disable iff (reset)
        (dcache_request.valid && !stall && !expect_hit) |=> (stall && !dcache_response.valid))
        else begin
            errors++;
            $display("ERR %0t: miss did not raise stall", $time);
        end

    a_stall_release: assert property (@(posedge clock) disable iff (reset)
        $fell(stall) |-> dcache_response.valid)
        else begin
            errors++;
            $display("ERR %0t: stall fell without a response", $time);
        end

    a_response_source: assert property (@(posedge clock) disable iff (reset)
        dcache_response.valid |-> (!stall && ($past(hit_issue) || $past(stall))))
        else begin
            errors++;
            $display("ERR %0t: response neither after a hit nor at the end of a stall", $time);
        end

    a_hold_while_refused: assert property (@(posedge clock) disable iff (reset)
        (mem_command != dcache_pkg::cmd_none && mem_response == '0) |=>
        (mem_command == $past(mem_command) && mem_addr == $past(mem_addr) &&
         mem_data == $past(mem_data)))
        else begin
            errors++;
            $display("ERR %0t: memory command changed while refused", $time);
        end

    initial begin
        dcache_pkg::addr_t     addr;
        dcache_pkg::mem_size_e size;
        dcache_pkg::mem_op_e   op;
        int                    off;
        clock          = 1'b0;
        reset          = 1'b1;
        dcache_request = '0;
        exp_data       = '0;
        resp_expect    = '0;
        expect_hit     = 1'b0;
        started        = 1'b0;
        errors         = 0;
        timeouts       = 0;
        for (int i = 0; i < `DC_N_LINES; i++) begin
            res_valid[i] = 1'b0;
            res_tag[i]   = '0;
        end
        repeat (16) @(posedge clock);
        #1;
        reset = 1'b0;
        repeat (4) @(posedge clock);   // idle window
        #1;
        access(dcache_pkg::op_read,  dcache_pkg::size_word, 32'h0000_0104, '0);
        access(dcache_pkg::op_read,  dcache_pkg::size_byte, 32'h0000_0103, '0);
        access(dcache_pkg::op_read,  dcache_pkg::size_half, 32'h0000_0106, '0);
        access(dcache_pkg::op_write, dcache_pkg::size_byte, 32'h0000_0101, 32'h0000_00c3);
        access(dcache_pkg::op_write, dcache_pkg::size_half, 32'h0000_0102, 32'h0000_beef);
        access(dcache_pkg::op_write, dcache_pkg::size_word, 32'h0000_0104, 32'h1234_5678);
        access(dcache_pkg::op_read,  dcache_pkg::size_word, 32'h0000_0100, '0);
        access(dcache_pkg::op_read,  dcache_pkg::size_half, 32'h0000_0106, '0);
        // same index, other tag, the dirty line has to be written back
        access(dcache_pkg::op_write, dcache_pkg::size_word, 32'h0000_0184, 32'hcafe_f00d);
        access(dcache_pkg::op_read,  dcache_pkg::size_word, 32'h0000_0100, '0);
        access(dcache_pkg::op_read,  dcache_pkg::size_word, 32'h0000_0104, '0);
        access(dcache_pkg::op_read,  dcache_pkg::size_word, 32'h0000_0184, '0);
        for (int i = 0; i < 60; i++) begin
            size = dcache_pkg::mem_size_e'(i % 3);
            off  = (i * 7) % 8;
            off  = off & ~((1 << size) - 1);   // aligned to the access size
            op   = (i % 4 == 1) ? dcache_pkg::op_write : dcache_pkg::op_read;
            addr = 32'h0000_2000 + ((i / 5) % 3) * 128 + ((i * 3) % 8) * 8 + off;
            access(op, size, addr, 32'h5a00_0000 + i * 32'h0001_0307);
        end
        dcache_request = '0;
        repeat (4) @(posedge clock);
        $display("assertion errors: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

/* tb/dc_mem_model.sv */
`timescale 1ns/10ps

module dc_mem_model (
    input  logic                 clock,
    input  logic                 reset,
    input  dcache_pkg::mem_cmd_e mem_command,
    input  dcache_pkg::addr_t    mem_addr,
    input  dcache_pkg::block_t   mem_data,
    output dcache_pkg::mem_tag_t mem_response,
    output dcache_pkg::mem_tag_t mem_fill_tag,
    output dcache_pkg::block_t   mem_fill_data
);

    dcache_pkg::block_t   stored [dcache_pkg::addr_t];   // lines written back so far
    dcache_pkg::mem_tag_t pend_tag [$];                  // accepted loads, not yet returned
    dcache_pkg::block_t   pend_data [$];
    logic [7:0]           lfsr;
    logic                 refuse;
    dcache_pkg::mem_tag_t next_tag;

    function automatic logic [7:0] lfsr_next(input logic [7:0] s);
        return s[0] ? ((s >> 1) ^ 8'hb8) : (s >> 1);
    endfunction

    // one shift per bit taken
    task automatic draw_bits(input int n, output int val);
        val = 0;
        for (int k = 0; k < n; k++) begin
            val  = (val << 1) | lfsr[0];
            lfsr = lfsr_next(lfsr);
        end
    endtask

    // accept tag goes out in the same cycle as the command
    assign mem_response = (mem_command != dcache_pkg::cmd_none && !refuse) ? next_tag : '0;

    initial begin
        lfsr          = 8'd81;
        refuse        = 1'b0;
        next_tag      = 1;
        mem_fill_tag  = '0;
        mem_fill_data = '0;
    end

    always @(posedge clock) begin
        dcache_pkg::mem_cmd_e cmd;
        dcache_pkg::addr_t    addr;
        dcache_pkg::block_t   data;
        dcache_pkg::mem_tag_t tag;
        logic                 rst;
        int                   go;
        int                   pick;
        cmd  = mem_command;   // values seen by the DUT at this edge
        addr = mem_addr;
        data = mem_data;
        tag  = mem_response;
        rst  = reset;
        #1;
        mem_fill_tag = '0;
        if (rst) begin
            refuse   = 1'b0;
            next_tag = 1;
            pend_tag.delete();
            pend_data.delete();
        end else begin
            if (pend_tag.size() > 0) begin
                draw_bits(1, go);
                if (go == 1) begin
                    draw_bits(2, pick);
                    pick          = pick % pend_tag.size();   // any pending load, not the oldest
                    mem_fill_tag  = pend_tag[pick];
                    mem_fill_data = pend_data[pick];
                    pend_tag.delete(pick);
                    pend_data.delete(pick);
                end
            end
            if (cmd != dcache_pkg::cmd_none && tag != '0) begin
                if (cmd == dcache_pkg::cmd_store) begin
                    stored[addr] = data;
                end else begin
                    pend_tag.push_back(tag);
                    pend_data.push_back(stored.exists(addr) ? stored[addr] : {addr, addr});
                end
                next_tag = (next_tag == '1) ? 1 : next_tag + 1'b1;   // zero is never a tag
            end
            draw_bits(2, pick);
            refuse = (pick == 0);
        end
    end

endmodule

/* verilog/dcache_top.sv */
`timescale 1ns/10ps
`include "dcache_defs.svh"

module dcache_top (
    input  logic                     clock,
    input  logic                     reset,
    input  dcache_pkg::dc_request_t  dcache_request,
    output logic                     stall,
    output dcache_pkg::dc_response_t dcache_response,
    output dcache_pkg::mem_cmd_e     mem_command,
    output dcache_pkg::addr_t        mem_addr,
    output dcache_pkg::block_t       mem_data,
    input  dcache_pkg::mem_tag_t     mem_response,
    input  dcache_pkg::mem_tag_t     mem_fill_tag,
    input  dcache_pkg::block_t       mem_fill_data
);

    logic                         hit;
    dcache_pkg::cache_line_t      hit_line;
    logic                         store_en;
    dcache_pkg::line_xfer_t       alloc_req;
    dcache_pkg::line_xfer_t       fill;     // table to array and controller
    dcache_pkg::line_xfer_t       victim;   // array to table
    dcache_pkg::addr_t            lookup_addr;
    logic [`DC_MSHR_CNT_BITS-1:0] n_free;
    logic                         line_pending;

    dc_request_ctrl u_ctrl (
        .clock           (clock),
        .reset           (reset),
        .dcache_request  (dcache_request),
        .hit             (hit),
        .hit_line        (hit_line),
        .fill            (fill),
        .n_free          (n_free),
        .line_pending    (line_pending),
        .stall           (stall),
        .store_en        (store_en),
        .alloc_req       (alloc_req),
        .lookup_addr     (lookup_addr),
        .dcache_response (dcache_response)
    );

    // any pending entry blocks the request, so the kind of entry is not needed here
    dc_mshr u_mshr (
        .clock            (clock),
        .reset            (reset),
        .alloc_req        (alloc_req),
        .victim           (victim),
        .lookup_addr      (lookup_addr),
        .n_free           (n_free),
        .line_pending     (line_pending),
        .pending_is_write (),
        .mem_command      (mem_command),
        .mem_addr         (mem_addr),
        .mem_data         (mem_data),
        .mem_response     (mem_response),
        .mem_fill_tag     (mem_fill_tag),
        .mem_fill_data    (mem_fill_data),
        .fill             (fill)
    );

    dc_line_array u_array (
        .clock    (clock),
        .reset    (reset),
        .req      (dcache_request),
        .store_en (store_en),
        .hit      (hit),
        .hit_line (hit_line),
        .fill     (fill),
        .victim   (victim)
    );

endmodule

/* verilog/dc_request_ctrl.sv */
`timescale 1ns/10ps
`include "dcache_defs.svh"

module dc_request_ctrl (
    input  logic                          clock,
    input  logic                          reset,
    input  dcache_pkg::dc_request_t       dcache_request,
    input  logic                          hit,
    input  dcache_pkg::cache_line_t       hit_line,
    input  dcache_pkg::line_xfer_t        fill,
    input  logic [`DC_MSHR_CNT_BITS-1:0]  n_free,
    input  logic                          line_pending,
    output logic                          stall,
    output logic                          store_en,
    output dcache_pkg::line_xfer_t        alloc_req,
    output dcache_pkg::addr_t             lookup_addr,
    output dcache_pkg::dc_response_t      dcache_response
);

    dcache_pkg::dc_state_e    state;
    dcache_pkg::dc_state_e    next_state;
    dcache_pkg::dc_request_t  req_q;        // request waiting on a miss
    logic                     hit_done;
    logic                     fill_match;
    logic                     can_alloc;
    dcache_pkg::dc_request_t  resp_req;
    dcache_pkg::block_t       resp_block;
    dcache_pkg::dc_response_t next_response;

    // pull the addressed field out of a line, zero extended
    function automatic dcache_pkg::word_t extract(
        input dcache_pkg::block_t      blk,
        input dcache_pkg::dc_request_t r
    );
        dcache_pkg::word_t      data;
        logic [`DC_BO_BITS-1:0] off;
        data = '0;
        off  = r.addr[`DC_BO_BITS-1:0];
        case (r.size)
            dcache_pkg::size_byte: data[7:0]  = blk[off*8 +: 8];
            dcache_pkg::size_half: data[15:0] = blk[(off >> 1)*16 +: 16];
            default:               data[31:0] = blk[(off >> 2)*32 +: 32];
        endcase
        return data;
    endfunction

    assign stall       = (state != dcache_pkg::st_ready);
    assign lookup_addr = req_q.addr;

    assign hit_done   = (state == dcache_pkg::st_ready) && dcache_request.valid && hit;
    assign fill_match = (state == dcache_pkg::st_wait_fill) && fill.valid &&
                        (fill.line_addr[`DC_XLEN-1:`DC_BO_BITS] == req_q.addr[`DC_XLEN-1:`DC_BO_BITS]);
    assign can_alloc  = (state == dcache_pkg::st_wait_mshr) && (n_free >= 2) && !line_pending;

    assign store_en = (hit_done && dcache_request.op == dcache_pkg::op_write) ||
                      (fill_match && req_q.op == dcache_pkg::op_write);

    assign alloc_req.valid     = can_alloc;
    assign alloc_req.line_addr = {req_q.addr[`DC_XLEN-1:`DC_BO_BITS], {`DC_BO_BITS{1'b0}}};
    assign alloc_req.block     = '0;

    always_comb begin
        next_state = state;
        case (state)
            dcache_pkg::st_ready: begin
                if (dcache_request.valid && !hit) next_state = dcache_pkg::st_wait_mshr;
            end
            dcache_pkg::st_wait_mshr: begin
                if (can_alloc) next_state = dcache_pkg::st_wait_fill;
            end
            dcache_pkg::st_wait_fill: begin
                if (fill_match) next_state = dcache_pkg::st_ready;
            end
            default: next_state = dcache_pkg::st_ready;
        endcase
    end

    // a hit answers from the array, a finished miss from the fill data
    assign resp_req   = hit_done ? dcache_request : req_q;
    assign resp_block = hit_done ? hit_line.block : fill.block;

    always_comb begin
        next_response.valid = hit_done || fill_match;
        next_response.data  = '0;   // stores return zero
        if (next_response.valid && resp_req.op == dcache_pkg::op_read) begin
            next_response.data = extract(resp_block, resp_req);
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state           <= dcache_pkg::st_ready;
            dcache_response <= '0;
        end else begin
            state           <= next_state;
            dcache_response <= next_response;
        end
    end

    always_ff @(posedge clock) begin
        if (state == dcache_pkg::st_ready && dcache_request.valid && !hit) begin
            req_q <= dcache_request;
        end
    end

    a_state_known: assert property (@(posedge clock) disable iff (reset) !$isunknown(state));

endmodule

/* verilog/dc_mshr.sv */
`timescale 1ns/10ps
`include "dcache_defs.svh"

module dc_mshr (
    input  logic                          clock,
    input  logic                          reset,
    input  dcache_pkg::line_xfer_t        alloc_req,
    input  dcache_pkg::line_xfer_t        victim,
    input  dcache_pkg::addr_t             lookup_addr,
    output logic [`DC_MSHR_CNT_BITS-1:0]  n_free,
    output logic                          line_pending,
    output logic                          pending_is_write,
    output dcache_pkg::mem_cmd_e          mem_command,
    output dcache_pkg::addr_t             mem_addr,
    output dcache_pkg::block_t            mem_data,
    input  dcache_pkg::mem_tag_t          mem_response,
    input  dcache_pkg::mem_tag_t          mem_fill_tag,
    input  dcache_pkg::block_t            mem_fill_data,
    output dcache_pkg::line_xfer_t        fill
);

    dcache_pkg::mshr_entry_t entries_q [`DC_N_MSHR];
    dcache_pkg::mshr_entry_t entries_d [`DC_N_MSHR];

    logic                         issue_valid;
    logic [`DC_MSHR_IDX_BITS-1:0] issue_idx;
    logic                         accept;
    logic                         fill_hit;
    logic [`DC_MSHR_IDX_BITS-1:0] fill_idx;
    logic                         found_a;
    logic                         found_b;
    logic [`DC_MSHR_IDX_BITS-1:0] free_a;   // first free slot
    logic [`DC_MSHR_IDX_BITS-1:0] free_b;   // second free slot

    // untagged entries only; writes beat reads, lowest index within each
    always_comb begin
        issue_valid = 1'b0;
        issue_idx   = '0;
        for (int i = `DC_N_MSHR-1; i >= 0; i--) begin
            if (entries_q[i].valid && entries_q[i].mem_tag == '0 &&
                entries_q[i].op == dcache_pkg::op_read) begin
                issue_valid = 1'b1;
                issue_idx   = i[`DC_MSHR_IDX_BITS-1:0];
            end
        end
        for (int i = `DC_N_MSHR-1; i >= 0; i--) begin
            if (entries_q[i].valid && entries_q[i].mem_tag == '0 &&
                entries_q[i].op == dcache_pkg::op_write) begin
                issue_valid = 1'b1;
                issue_idx   = i[`DC_MSHR_IDX_BITS-1:0];
            end
        end
    end

    always_comb begin
        if (!issue_valid) begin
            mem_command = dcache_pkg::cmd_none;
        end else if (entries_q[issue_idx].op == dcache_pkg::op_write) begin
            mem_command = dcache_pkg::cmd_store;
        end else begin
            mem_command = dcache_pkg::cmd_load;
        end
    end

    assign mem_addr = entries_q[issue_idx].line_addr;
    assign mem_data = entries_q[issue_idx].block;
    assign accept   = issue_valid && (mem_response != '0);

    // returning data is matched by the tag recorded at accept
    always_comb begin
        fill_hit = 1'b0;
        fill_idx = '0;
        for (int i = 0; i < `DC_N_MSHR; i++) begin
            if (entries_q[i].valid && entries_q[i].op == dcache_pkg::op_read &&
                mem_fill_tag != '0 && entries_q[i].mem_tag == mem_fill_tag) begin
                fill_hit = 1'b1;
                fill_idx = i[`DC_MSHR_IDX_BITS-1:0];
            end
        end
    end

    assign fill.valid     = fill_hit;
    assign fill.line_addr = entries_q[fill_idx].line_addr;
    assign fill.block     = mem_fill_data;

    // free slots and the pending check for the waiting request
    always_comb begin
        n_free           = '0;
        found_a          = 1'b0;
        found_b          = 1'b0;
        free_a           = '0;
        free_b           = '0;
        line_pending     = 1'b0;
        pending_is_write = 1'b0;
        for (int i = 0; i < `DC_N_MSHR; i++) begin
            if (!entries_q[i].valid) begin
                n_free = n_free + 1'b1;
                if (!found_a) begin
                    found_a = 1'b1;
                    free_a  = i[`DC_MSHR_IDX_BITS-1:0];
                end else if (!found_b) begin
                    found_b = 1'b1;
                    free_b  = i[`DC_MSHR_IDX_BITS-1:0];
                end
            end else if (entries_q[i].line_addr[`DC_XLEN-1:`DC_BO_BITS] ==
                         lookup_addr[`DC_XLEN-1:`DC_BO_BITS]) begin
                line_pending     = 1'b1;
                pending_is_write = (entries_q[i].op == dcache_pkg::op_write);
            end
        end
    end

    always_comb begin
        entries_d = entries_q;
        if (accept) begin
            if (entries_q[issue_idx].op == dcache_pkg::op_write) begin
                entries_d[issue_idx] = '0;   // memory took the store
            end else begin
                entries_d[issue_idx].mem_tag = mem_response;
            end
        end
        if (fill_hit) begin
            entries_d[fill_idx] = '0;
        end
        if (victim.valid) begin
            entries_d[free_a] = '{valid: 1'b1, op: dcache_pkg::op_write, mem_tag: '0,
                                  line_addr: victim.line_addr, block: victim.block};
        end
        if (alloc_req.valid) begin
            entries_d[victim.valid ? free_b : free_a] = '{valid: 1'b1,
                op: dcache_pkg::op_read, mem_tag: '0,
                line_addr: alloc_req.line_addr, block: '0};
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < `DC_N_MSHR; i++) begin
                entries_q[i].valid   <= 1'b0;
                entries_q[i].mem_tag <= '0;
            end
        end else begin
            entries_q <= entries_d;
        end
    end

    // the controller waits for two free slots so an eviction always lands
    a_alloc_capacity: assert property (@(posedge clock) disable iff (reset)
        (victim.valid || alloc_req.valid) |-> (n_free >= victim.valid + alloc_req.valid));

    // a returning tag always names a tagged read entry
    a_fill_is_read: assert property (@(posedge clock) disable iff (reset)
        (mem_fill_tag != '0) |-> fill_hit);

endmodule

/* verilog/dc_line_array.sv */
`timescale 1ns/10ps
`include "dcache_defs.svh"

module dc_line_array (
    input  logic                    clock,
    input  logic                    reset,
    input  dcache_pkg::dc_request_t req,
    input  logic                    store_en,
    output logic                    hit,
    output dcache_pkg::cache_line_t hit_line,
    input  dcache_pkg::line_xfer_t  fill,
    output dcache_pkg::line_xfer_t  victim
);

    logic [`DC_N_LINES-1:0] line_valid;
    logic [`DC_N_LINES-1:0] line_dirty;
    dcache_pkg::line_tag_t  line_tag  [`DC_N_LINES];
    dcache_pkg::block_t     line_data [`DC_N_LINES];

    dcache_pkg::line_idx_t  req_idx;
    dcache_pkg::line_tag_t  req_tag;
    dcache_pkg::line_idx_t  fill_idx;
    dcache_pkg::line_tag_t  fill_tag;
    logic                   store_into_fill;   // store miss finishing on this fill
    dcache_pkg::block_t     store_base;
    dcache_pkg::block_t     store_block;

    // drop the byte, half or word of a store into its place in the line
    function automatic dcache_pkg::block_t merge_store(
        input dcache_pkg::block_t      blk,
        input dcache_pkg::dc_request_t r
    );
        dcache_pkg::block_t     merged;
        logic [`DC_BO_BITS-1:0] off;
        merged = blk;
        off    = r.addr[`DC_BO_BITS-1:0];
        case (r.size)
            dcache_pkg::size_byte: merged[off*8 +: 8] = r.wdata[7:0];
            dcache_pkg::size_half: merged[(off >> 1)*16 +: 16] = r.wdata[15:0];
            default:               merged[(off >> 2)*32 +: 32] = r.wdata[31:0];
        endcase
        return merged;
    endfunction

    assign req_idx  = req.addr[`DC_BO_BITS +: `DC_IDX_BITS];
    assign req_tag  = req.addr[`DC_XLEN-1 -: `DC_TAG_BITS];
    assign fill_idx = fill.line_addr[`DC_BO_BITS +: `DC_IDX_BITS];
    assign fill_tag = fill.line_addr[`DC_XLEN-1 -: `DC_TAG_BITS];

    assign hit_line.valid = line_valid[req_idx];
    assign hit_line.dirty = line_dirty[req_idx];
    assign hit_line.tag   = line_tag[req_idx];
    assign hit_line.block = line_data[req_idx];
    assign hit = req.valid && line_valid[req_idx] && (line_tag[req_idx] == req_tag);

    assign store_into_fill = fill.valid && store_en && (fill_idx == req_idx);
    assign store_base      = store_into_fill ? fill.block : line_data[req_idx];
    assign store_block     = merge_store(store_base, req);

    // the displaced line goes out in the fill cycle, clean ones are dropped
    always_comb begin
        victim.valid     = fill.valid && line_valid[fill_idx] && line_dirty[fill_idx];
        victim.line_addr = {line_tag[fill_idx], fill_idx, {`DC_BO_BITS{1'b0}}};
        victim.block     = line_data[fill_idx];
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            line_valid <= '0;
            line_dirty <= '0;
        end else if (fill.valid) begin
            line_valid[fill_idx] <= 1'b1;
            line_dirty[fill_idx] <= store_into_fill;   // clean unless a store rides along
        end else if (store_en) begin
            line_dirty[req_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (fill.valid) begin
            line_tag[fill_idx]  <= fill_tag;
            line_data[fill_idx] <= store_into_fill ? store_block : fill.block;
        end else if (store_en) begin
            line_data[req_idx] <= store_block;   // store hit
        end
    end

    // the controller only allocates reads for lines that missed here
    a_fill_not_resident: assert property (@(posedge clock) disable iff (reset)
        fill.valid |-> !(line_valid[fill_idx] && (line_tag[fill_idx] == fill_tag)));

endmodule

/* verilog/dcache_pkg.sv */
`include "dcache_defs.svh"

package dcache_pkg;

    typedef logic [`DC_XLEN-1:0]         addr_t;
    typedef logic [`DC_BLOCK_BITS-1:0]   block_t;
    typedef logic [`DC_TAG_BITS-1:0]     line_tag_t;
    typedef logic [`DC_IDX_BITS-1:0]     line_idx_t;
    typedef logic [`DC_MEM_TAG_BITS-1:0] mem_tag_t;
    typedef logic [`DC_WORD_BITS-1:0]    word_t;

    // memory bus command
    typedef enum logic [1:0] {
        cmd_none  = 2'd0,
        cmd_load  = 2'd1,
        cmd_store = 2'd2
    } mem_cmd_e;

    typedef enum logic [1:0] {
        size_byte = 2'd0,
        size_half = 2'd1,
        size_word = 2'd2
    } mem_size_e;

    typedef enum logic {
        op_read  = 1'b0,
        op_write = 1'b1
    } mem_op_e;

    typedef enum logic [1:0] {
        st_ready     = 2'd0,
        st_wait_mshr = 2'd1,   // miss seen, waiting for table room
        st_wait_fill = 2'd2
    } dc_state_e;

    typedef struct packed {
        logic      valid;
        mem_op_e   op;
        mem_size_e size;
        addr_t     addr;
        word_t     wdata;
    } dc_request_t;

    typedef struct packed {
        logic  valid;
        word_t data;
    } dc_response_t;

    typedef struct packed {
        logic      valid;
        logic      dirty;
        line_tag_t tag;
        block_t    block;
    } cache_line_t;

    typedef struct packed {
        logic     valid;
        mem_op_e  op;
        mem_tag_t mem_tag;     // zero until the memory accepts
        addr_t    line_addr;
        block_t   block;
    } mshr_entry_t;

    // fill from the table or victim from the array
    typedef struct packed {
        logic   valid;
        addr_t  line_addr;
        block_t block;
    } line_xfer_t;

endpackage

/* verilog/dcache_defs.svh */
`ifndef DCACHE_DEFS_SVH
`define DCACHE_DEFS_SVH

// address and register widths
`define DC_XLEN          32
`define DC_WORD_BITS     32

// line geometry, direct mapped
`define DC_BLOCK_BYTES   8
`define DC_BLOCK_BITS    (`DC_BLOCK_BYTES * 8)
`define DC_BO_BITS       $clog2(`DC_BLOCK_BYTES)   // block offset
`define DC_N_LINES       16
`define DC_IDX_BITS      $clog2(`DC_N_LINES)
`define DC_TAG_BITS      (`DC_XLEN - `DC_IDX_BITS - `DC_BO_BITS)

// miss status table
`define DC_N_MSHR        4
`define DC_MSHR_IDX_BITS $clog2(`DC_N_MSHR)
`define DC_MSHR_CNT_BITS $clog2(`DC_N_MSHR + 1)   // free count, 0 to N

// memory port tag, zero means no response
`define DC_MEM_TAG_BITS  4

`endif
